/* lc3b_macros.svh */
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// PC value taken on reset.
`define LC3B_RESET_PC 16'h0000

// Number of general purpose registers.
`define LC3B_NUM_REGS 8

// Cycles a memory request may be held before it counts as lost.
`define LC3B_MEM_TIMEOUT 64

`endif

/* lc3b_types.sv */
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0]  lc3b_reg;
typedef logic [3:0]  lc3b_imm4;
typedef logic [4:0]  lc3b_imm5;
typedef logic [5:0]  lc3b_offset6;
typedef logic [8:0]  lc3b_offset9;
typedef logic [2:0]  lc3b_nzp;

typedef enum logic [3:0] {
    op_br   = 4'b0000,
    op_add  = 4'b0001,
    op_ldb  = 4'b0010,
    op_stb  = 4'b0011,
    op_jsr  = 4'b0100,
    op_and  = 4'b0101,
    op_ldr  = 4'b0110,
    op_str  = 4'b0111,
    op_rti  = 4'b1000,
    op_not  = 4'b1001,
    op_ldi  = 4'b1010,
    op_sti  = 4'b1011,
    op_jmp  = 4'b1100,
    op_shf  = 4'b1101,
    op_lea  = 4'b1110,
    op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [2:0] {
    alu_add,
    alu_and,
    alu_not,
    alu_sll,
    alu_srl,
    alu_sra
} lc3b_aluop;

typedef enum logic [3:0] {
    fetch1, fetch2, fetch3, decode, alu, lea, br, br_taken,
    jmp, calc_addr, ldr1, ldr2, str1, str2
} lc3b_state;

typedef struct packed {
    logic       load_pc;
    logic       load_ir;
    logic       load_regfile;
    logic       load_mar;
    logic       load_mdr;
    logic       load_cc;
    logic [1:0] pcmux_sel;
    logic       storemux_sel;
    logic [2:0] alumux_sel;
    logic [1:0] regfilemux_sel;
    logic       marmux_sel;
    logic       mdrmux_sel;
    lc3b_aluop  aluop;
} lc3b_ctrl;

endpackage : lc3b_types

/* alu.sv */
`timescale 1ns/1ns

module alu (
    input  lc3b_types::lc3b_aluop aluop,
    input  lc3b_types::lc3b_word  a,
    input  lc3b_types::lc3b_word  b,
    output lc3b_types::lc3b_word  f
);
    import lc3b_types::*;

    logic [3:0] shamt;

    // Shifts use only the low four bits of the operand.
    assign shamt = b[3:0];

    always_comb begin
        case (aluop)
            alu_add: f = a + b;
            alu_and: f = a & b;
            alu_not: f = ~a;
            alu_sll: f = a << shamt;
            alu_srl: f = a >> shamt;
            alu_sra: f = lc3b_word'($signed(a) >>> shamt);
            default: f = a + b;
        endcase
    end

endmodule : alu

/* regfile.sv */
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  lc3b_types::lc3b_word in,
    input  lc3b_types::lc3b_reg  src_a,
    input  lc3b_types::lc3b_reg  src_b,
    input  lc3b_types::lc3b_reg  dest,
    output lc3b_types::lc3b_word reg_a,
    output lc3b_types::lc3b_word reg_b
);
    import lc3b_types::*;

    lc3b_word regs [`LC3B_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= in;
        end
    end

    // No write bypass; a read sees the value stored before the edge.
    assign reg_a = regs[src_a];
    assign reg_b = regs[src_b];

endmodule : regfile

/* datapath.sv */
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module datapath (
    input  logic                   clk,
    input  logic                   reset,
    input  lc3b_types::lc3b_ctrl   ctrl,
    input  lc3b_types::lc3b_word   mem_rdata,
    output lc3b_types::lc3b_word   mem_address,
    output lc3b_types::lc3b_word   mem_wdata,
    output lc3b_types::lc3b_opcode opcode,
    output logic                   inst4,
    output logic                   inst5,
    output logic                   branch_enable
);
    import lc3b_types::*;

    lc3b_word    pc;
    lc3b_word    ir;
    lc3b_word    mar;
    lc3b_word    mdr;
    lc3b_nzp     cc;
    lc3b_nzp     gencc_out;

    lc3b_reg     dest;
    lc3b_reg     sr1;
    lc3b_reg     sr2;
    lc3b_reg     storemux_out;
    lc3b_imm4    imm4;
    lc3b_imm5    imm5;
    lc3b_offset6 offset6;
    lc3b_offset9 offset9;

    lc3b_word    sr1_out;
    lc3b_word    sr2_out;
    lc3b_word    pc_plus2;
    lc3b_word    adj6_out;
    lc3b_word    adj9_out;
    lc3b_word    bradd_out;
    lc3b_word    pcmux_out;
    lc3b_word    alumux_out;
    lc3b_word    alu_out;
    lc3b_word    regfilemux_out;
    lc3b_word    marmux_out;
    lc3b_word    mdrmux_out;

    // Instruction field decode.
    assign opcode  = lc3b_opcode'(ir[15:12]);
    assign dest    = ir[11:9];
    assign sr1     = ir[8:6];
    assign sr2     = ir[2:0];
    assign inst4   = ir[4];
    assign inst5   = ir[5];
    assign imm4    = ir[3:0];
    assign imm5    = ir[4:0];
    assign offset6 = ir[5:0];
    assign offset9 = ir[8:0];

    // Word offsets become byte offsets.
    assign adj6_out  = {{9{offset6[5]}}, offset6, 1'b0};
    assign adj9_out  = {{6{offset9[8]}}, offset9, 1'b0};
    assign pc_plus2  = pc + 16'd2;
    assign bradd_out = pc + adj9_out;

    // STR reads its source through the dest field.
    assign storemux_out = ctrl.storemux_sel ? dest : sr1;

    always_comb begin
        case (ctrl.pcmux_sel)
            2'd1:    pcmux_out = bradd_out;
            2'd2:    pcmux_out = sr1_out;
            default: pcmux_out = pc_plus2;
        endcase
        case (ctrl.alumux_sel)
            3'd1:    alumux_out = {{11{imm5[4]}}, imm5};
            3'd2:    alumux_out = adj6_out;
            3'd3:    alumux_out = {12'd0, imm4};
            default: alumux_out = sr2_out;
        endcase
        case (ctrl.regfilemux_sel)
            2'd1:    regfilemux_out = mdr;
            2'd2:    regfilemux_out = bradd_out;
            default: regfilemux_out = alu_out;
        endcase
    end

    assign marmux_out = ctrl.marmux_sel ? pc : alu_out;
    assign mdrmux_out = ctrl.mdrmux_sel ? mem_rdata : sr1_out;

    regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .load  (ctrl.load_regfile),
        .in    (regfilemux_out),
        .src_a (storemux_out),
        .src_b (sr2),
        .dest  (dest),
        .reg_a (sr1_out),
        .reg_b (sr2_out)
    );

    alu u_alu (
        .aluop (ctrl.aluop),
        .a     (sr1_out),
        .b     (alumux_out),
        .f     (alu_out)
    );

    assign gencc_out[2] = regfilemux_out[15];
    assign gencc_out[1] = (regfilemux_out == 16'd0);
    assign gencc_out[0] = ~regfilemux_out[15] & (regfilemux_out != 16'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `LC3B_RESET_PC;
            cc <= '0;
        end else begin
            if (ctrl.load_pc) pc <= pcmux_out;
            if (ctrl.load_cc) cc <= gencc_out;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_ir)  ir  <= mdr;
        if (ctrl.load_mar) mar <= marmux_out;
        if (ctrl.load_mdr) mdr <= mdrmux_out;
    end

    // The nzp mask of a BR sits in the dest field.
    assign branch_enable = |(dest & cc);

    assign mem_address = mar;
    assign mem_wdata   = mdr;

    // IR copies MDR, so MDR must be settled when IR loads.
    assert property (@(posedge clk) disable iff (reset) !(ctrl.load_ir && ctrl.load_mdr))
        else $error("load_ir and load_mdr high in the same cycle");

endmodule : datapath

/* control.sv */
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module control (
    input  logic                   clk,
    input  logic                   reset,
    input  lc3b_types::lc3b_opcode opcode,
    input  logic                   inst4,
    input  logic                   inst5,
    input  logic                   branch_enable,
    input  logic                   mem_resp,
    output lc3b_types::lc3b_ctrl   ctrl,
    output logic                   mem_read,
    output logic                   mem_write
);
    import lc3b_types::*;

    lc3b_state state;
    lc3b_state next_state;

    logic [$clog2(`LC3B_MEM_TIMEOUT):0] wait_count;

    always_comb begin
        ctrl       = '0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        next_state = state;
        case (state)
            fetch1: begin
                ctrl.marmux_sel = 1'b1;
                ctrl.load_mar   = 1'b1;
                ctrl.load_pc    = 1'b1;
                next_state      = fetch2;
            end
            fetch2: begin
                mem_read        = 1'b1;
                ctrl.mdrmux_sel = 1'b1;
                ctrl.load_mdr   = mem_resp;
                if (mem_resp) next_state = fetch3;
            end
            fetch3: begin
                ctrl.load_ir = 1'b1;
                next_state   = decode;
            end
            decode: begin
                case (opcode)
                    op_add, op_and, op_not, op_shf: next_state = alu;
                    op_lea:                         next_state = lea;
                    op_br:                          next_state = br;
                    op_jmp:                         next_state = jmp;
                    op_ldr, op_str:                 next_state = calc_addr;
                    default:                        next_state = fetch1;
                endcase
            end
            alu: begin
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                case (opcode)
                    op_and: begin
                        ctrl.aluop      = alu_and;
                        ctrl.alumux_sel = inst5 ? 3'd1 : 3'd0;
                    end
                    op_not: ctrl.aluop = alu_not;
                    op_shf: begin
                        ctrl.alumux_sel = 3'd3;
                        if (!inst4)
                            ctrl.aluop = alu_sll;
                        else
                            ctrl.aluop = inst5 ? alu_sra : alu_srl;
                    end
                    default: begin
                        ctrl.aluop      = alu_add;
                        ctrl.alumux_sel = inst5 ? 3'd1 : 3'd0;
                    end
                endcase
                next_state = fetch1;
            end
            lea: begin
                ctrl.regfilemux_sel = 2'd2;
                ctrl.load_regfile   = 1'b1;
                next_state          = fetch1;
            end
            br: next_state = branch_enable ? br_taken : fetch1;
            br_taken: begin
                ctrl.pcmux_sel = 2'd1;
                ctrl.load_pc   = 1'b1;
                next_state     = fetch1;
            end
            jmp: begin
                ctrl.pcmux_sel = 2'd2;
                ctrl.load_pc   = 1'b1;
                next_state     = fetch1;
            end
            calc_addr: begin
                ctrl.alumux_sel = 3'd2;
                ctrl.aluop      = alu_add;
                ctrl.load_mar   = 1'b1;
                next_state      = (opcode == op_ldr) ? ldr1 : str1;
            end
            ldr1: begin
                mem_read        = 1'b1;
                ctrl.mdrmux_sel = 1'b1;
                ctrl.load_mdr   = mem_resp;
                if (mem_resp) next_state = ldr2;
            end
            ldr2: begin
                ctrl.regfilemux_sel = 2'd1;
                ctrl.load_regfile   = 1'b1;
                ctrl.load_cc        = 1'b1;
                next_state          = fetch1;
            end
            str1: begin
                ctrl.storemux_sel = 1'b1;
                ctrl.load_mdr     = 1'b1;
                next_state        = str2;
            end
            str2: begin
                mem_write = 1'b1;
                if (mem_resp) next_state = fetch1;
            end
            default: next_state = fetch1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= fetch1;
        else
            state <= next_state;
    end

    // Cycles the current request has waited without a response.
    always_ff @(posedge clk) begin
        if (reset || mem_resp || !(mem_read || mem_write))
            wait_count <= '0;
        else
            wait_count <= wait_count + 1'b1;
    end

    assert property (@(posedge clk) disable iff (reset) !(mem_read && mem_write))
        else $error("mem_read and mem_write high together");
    assert property (@(posedge clk) disable iff (reset) mem_read && !mem_resp |=> mem_read)
        else $error("mem_read dropped before mem_resp");
    assert property (@(posedge clk) disable iff (reset) mem_write && !mem_resp |=> mem_write)
        else $error("mem_write dropped before mem_resp");
    assert property (@(posedge clk) disable iff (reset)
        (mem_read || mem_write) |-> wait_count < `LC3B_MEM_TIMEOUT)
        else $error("memory request held without mem_resp");

endmodule : control

/* cpu.sv */
`timescale 1ns/1ns

module cpu (
    input  logic                 clk,
    input  logic                 reset,
    input  lc3b_types::lc3b_word mem_rdata,
    input  logic                 mem_resp,
    output lc3b_types::lc3b_word mem_address,
    output lc3b_types::lc3b_word mem_wdata,
    output logic                 mem_read,
    output logic                 mem_write
);
    import lc3b_types::*;

    lc3b_ctrl   ctrl;
    lc3b_opcode opcode;
    logic       inst4;
    logic       inst5;
    logic       branch_enable;

    control u_control (
        .clk           (clk),
        .reset         (reset),
        .opcode        (opcode),
        .inst4         (inst4),
        .inst5         (inst5),
        .branch_enable (branch_enable),
        .mem_resp      (mem_resp),
        .ctrl          (ctrl),
        .mem_read      (mem_read),
        .mem_write     (mem_write)
    );

    datapath u_datapath (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (ctrl),
        .mem_rdata     (mem_rdata),
        .mem_address   (mem_address),
        .mem_wdata     (mem_wdata),
        .opcode        (opcode),
        .inst4         (inst4),
        .inst5         (inst5),
        .branch_enable (branch_enable)
    );

endmodule : cpu

/* tb_cpu.sv */
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module tb_cpu;
    import lc3b_types::*;

    localparam lc3b_word DATA_BASE  = 16'h0180;
    localparam int       IDLE_LIMIT = 32;
    localparam int       RUN_LIMIT  = 20000;

    logic        clk       = 1'b0;
    logic        reset     = 1'b1;
    lc3b_word    mem_rdata = '0;
    logic        mem_resp  = 1'b0;
    lc3b_word    mem_address;
    lc3b_word    mem_wdata;
    logic        mem_read;
    logic        mem_write;

    logic [31:0] rng = 32'hee39;
    lc3b_word    mem [256];
    int          prog_len;

    // Reference machine state.
    lc3b_word    model_mem [256];
    lc3b_word    model_regs [`LC3B_NUM_REGS];
    lc3b_nzp     model_cc;
    lc3b_word    model_pc;
    logic        store_pending;
    lc3b_word    exp_store_addr;
    lc3b_word    exp_store_data;
    logic        load_pending;
    lc3b_word    exp_load_addr;
    lc3b_word    halt_addr;
    int          halt_count;

    logic        busy;
    int          resp_delay;
    int          idle_cycles;
    logic        read_seen;
    logic        write_seen;

    cpu UUT (
        .clk         (clk),
        .reset       (reset),
        .mem_rdata   (mem_rdata),
        .mem_resp    (mem_resp),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .mem_read    (mem_read),
        .mem_write   (mem_write)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string reason);
        $display("Error at %0t ns: %s", $time, reason);
        fail_run();
    endtask

    task automatic compare_address(input string name, input lc3b_word actual,
                                   input lc3b_word expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
            fail_run();
        end
    endtask

    task automatic compare_store(input lc3b_word addr, input lc3b_word data,
                                 input lc3b_word exp_addr, input lc3b_word exp_data);
        if (addr !== exp_addr) begin
            $display("[FAIL] %0t ns mem_address: got %h, expected %h", $time, addr, exp_addr);
            fail_run();
        end else if (data !== exp_data) begin
            $display("[FAIL] %0t ns mem_wdata: got %h, expected %h", $time, data, exp_data);
            fail_run();
        end
    endtask

    function automatic void write_reg(input lc3b_reg r, input lc3b_word v);
        model_regs[r] = v;
        if (v[15])
            model_cc = 3'b100;
        else if (v == 16'd0)
            model_cc = 3'b010;
        else
            model_cc = 3'b001;
    endfunction

    // One instruction of the ISA; returns the next PC.
    function automatic lc3b_word lc3b_step(input lc3b_word pc, input lc3b_word instr,
                                           output logic st_valid, output lc3b_word st_addr,
                                           output lc3b_word st_data, output logic ld_valid,
                                           output lc3b_word ld_addr);
        lc3b_word   next_pc;
        lc3b_word   a;
        lc3b_word   b;
        lc3b_word   addr;
        lc3b_word   off9;
        logic [3:0] amt;
        lc3b_reg    d;
        next_pc  = pc + 16'd2;
        st_valid = 1'b0;
        st_addr  = '0;
        st_data  = '0;
        ld_valid = 1'b0;
        ld_addr  = '0;
        d        = instr[11:9];
        a        = model_regs[instr[8:6]];
        b        = instr[5] ? {{11{instr[4]}}, instr[4:0]} : model_regs[instr[2:0]];
        addr     = a + {{9{instr[5]}}, instr[5:0], 1'b0};
        off9     = {{6{instr[8]}}, instr[8:0], 1'b0};
        amt      = instr[3:0];
        case (lc3b_opcode'(instr[15:12]))
            op_add: write_reg(d, a + b);
            op_and: write_reg(d, a & b);
            op_not: write_reg(d, ~a);
            op_shf: begin
                if (!instr[4])
                    write_reg(d, a << amt);
                else if (!instr[5])
                    write_reg(d, a >> amt);
                else
                    write_reg(d, lc3b_word'({{16{a[15]}}, a} >> amt));
            end
            op_lea: model_regs[d] = next_pc + off9;
            op_br: begin
                if ((d & model_cc) != 3'b000)
                    next_pc = next_pc + off9;
            end
            op_jmp: next_pc = a;
            op_ldr: begin
                ld_valid = 1'b1;
                ld_addr  = addr;
                write_reg(d, model_mem[addr[8:1]]);
            end
            op_str: begin
                st_valid = 1'b1;
                st_addr  = addr;
                st_data  = model_regs[d];
                model_mem[addr[8:1]] = st_data;
            end
            default: ;
        endcase
        return next_pc;
    endfunction

    function automatic lc3b_word alu_instr(input int kind, input lc3b_reg d, input lc3b_reg s1,
                                           input lc3b_reg s2, input logic [4:0] imm);
        case (kind)
            0:       return {4'b0001, d, s1, 3'b000, s2};
            1:       return {4'b0001, d, s1, 1'b1, imm};
            2:       return {4'b0101, d, s1, 3'b000, s2};
            3:       return {4'b0101, d, s1, 1'b1, imm};
            4:       return {4'b1001, d, s1, 6'b111111};
            5:       return {4'b1101, d, s1, 2'b00, imm[3:0]};
            6:       return {4'b1101, d, s1, 2'b01, imm[3:0]};
            default: return {4'b1101, d, s1, 2'b11, imm[3:0]};
        endcase
    endfunction

    task automatic emit(input lc3b_word instr);
        mem[prog_len[7:0]] = instr;
        prog_len++;
    endtask

    task automatic build_program();
        lc3b_reg d;
        lc3b_reg s1;
        lc3b_reg s2;
        lc3b_nzp mask;
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = lc3b_word'((i * 16'h9e37) ^ 16'h5a5a);
        end
        for (int r = 0; r < 8; r++) begin
            emit({4'b0101, 3'(r), 3'(r), 1'b1, 5'd0});
        end
        for (int r = 0; r < 6; r++) begin
            rng = xorshift32(rng);
            emit({4'b0001, 3'(r), 3'(r), 1'b1, rng[4:0]});
        end
        // R7 = 3 << 7 is the data area base.
        emit({4'b0001, 3'd7, 3'd7, 1'b1, 5'd3});
        emit({4'b1101, 3'd7, 3'd7, 2'b00, 4'd7});
        for (int i = 0; i < 24; i++) begin
            rng = xorshift32(rng);
            d  = lc3b_reg'(rng[7:0] % 8'd6);
            s1 = lc3b_reg'(rng[15:8] % 8'd6);
            s2 = lc3b_reg'(rng[23:16] % 8'd6);
            emit(alu_instr(i % 8, d, s1, s2, rng[28:24]));
            emit({4'b0111, d, 3'd7, lc3b_offset6'((2 * i) % 32)});
            emit({4'b0110, 3'd6, 3'd7, lc3b_offset6'((2 * i) % 32)});
            emit({4'b0111, 3'd6, 3'd7, lc3b_offset6'((2 * i + 1) % 32)});
            rng = xorshift32(rng);
            if (i % 3 == 1) begin
                emit({4'b1110, 3'd6, rng[31:23]});
                emit({4'b0111, 3'd6, 3'd7, lc3b_offset6'((2 * i + 1) % 32)});
            end
            if (i % 3 == 2) begin
                case (i / 3)
                    0:       mask = 3'b111;
                    1:       mask = 3'b000;
                    default: mask = rng[23:21];
                endcase
                emit({4'b0000, mask, 9'd1});
                emit({4'b0001, d, d, 1'b1, 5'd1});
            end
        end
        // LEA points R5 at the final STR, two words past the JMP.
        emit({4'b1110, 3'd5, 9'd2});
        emit({4'b1100, 3'd0, 3'd5, 6'd0});
        emit({4'b0001, 3'd0, 3'd0, 1'b1, 5'd1});
        emit({4'b0111, 3'd5, 3'd7, 6'd31});
        halt_addr = lc3b_word'(prog_len << 1);
        emit({4'b0000, 3'b111, 9'h1ff});
    endtask

    // Memory answers each strobe after 0 to 5 cycles.
    always @(negedge clk) begin
        if (reset) begin
            mem_resp    = 1'b0;
            busy        = 1'b0;
            idle_cycles = 0;
        end else if (mem_resp) begin
            mem_resp = 1'b0;
        end else if (mem_read || mem_write) begin
            idle_cycles = 0;
            if (!busy) begin
                rng        = xorshift32(rng);
                resp_delay = int'(rng % 6);
                busy       = 1'b1;
            end
            if (resp_delay == 0) begin
                if (mem_read)
                    mem_rdata = mem[mem_address[8:1]];
                else
                    mem[mem_address[8:1]] = mem_wdata;
                mem_resp = 1'b1;
                busy     = 1'b0;
            end else begin
                resp_delay--;
            end
        end else begin
            idle_cycles++;
            if (idle_cycles > IDLE_LIMIT)
                abort_run("no memory request arrived within the idle limit");
        end
    end

    task automatic check_read_access();
        lc3b_word instr;
        if (mem_address >= DATA_BASE) begin
            if (!load_pending) begin
                abort_run("data read while no LDR was pending");
            end else begin
                compare_address("mem_address", mem_address, exp_load_addr);
                load_pending = 1'b0;
            end
        end else if (load_pending || store_pending) begin
            abort_run("fetch started while a data access was still due");
        end else begin
            compare_address("mem_address", mem_address, model_pc);
            if (model_pc == halt_addr)
                halt_count++;
            instr    = model_mem[model_pc[8:1]];
            model_pc = lc3b_step(model_pc, instr, store_pending, exp_store_addr,
                                 exp_store_data, load_pending, exp_load_addr);
        end
    endtask

    task automatic check_write_access();
        if (!store_pending) begin
            abort_run("write while no STR was pending");
        end else begin
            compare_store(mem_address, mem_wdata, exp_store_addr, exp_store_data);
            store_pending = 1'b0;
        end
    endtask

    // Each rising strobe is one access.
    always @(negedge clk) begin
        if (reset) begin
            read_seen  = 1'b0;
            write_seen = 1'b0;
        end else if (mem_read && mem_write) begin
            abort_run("mem_read and mem_write are high together");
        end else begin
            if (mem_read && !read_seen)
                check_read_access();
            if (mem_write && !write_seen)
                check_write_access();
            read_seen  = mem_read;
            write_seen = mem_write;
        end
    end

    initial begin : main
        int cycles;
        for (int r = 0; r < `LC3B_NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        model_cc      = '0;
        model_pc      = `LC3B_RESET_PC;
        store_pending = 1'b0;
        load_pending  = 1'b0;
        halt_count    = 0;
        build_program();
        model_mem = mem;
        repeat (8) @(negedge clk);
        reset  = 1'b0;
        cycles = 0;
        while (halt_count < 2 && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (halt_count < 2) begin
            abort_run("the halt loop was not fetched twice before the run limit");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule : tb_cpu

/* filelist.f */
+incdir+.
lc3b_types.sv
alu.sv
regfile.sv
datapath.sv
control.sv
cpu.sv
tb_cpu.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module tb_cpu -f filelist.f --Mdir obj_dir -o tb_cpu
	out=$$(./obj_dir/tb_cpu 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
